// File: dv/lsu_tb.sv
`timescale 1ns/1ps

module lsu_tb;

  localparam int  RST_CYCLES = 16;
  localparam int  MEM_WORDS  = 16;
  localparam time DRV_DELAY  = 5;

  typedef struct {
    lsu_pkg::lsu_op_e  op;
    lsu_pkg::word_t    pc;
    lsu_pkg::reg_idx_t rd;
    lsu_pkg::word_t    rs1;
    lsu_pkg::imm_t     imm;
    lsu_pkg::word_t    rs2;
    lsu_pkg::word_t    exp_data;
    logic              exp_trap;
    lsu_pkg::sel_t     exp_sel;
  } row_t;

  logic              clk;
  logic              rst;
  logic              dpu_vld_i;
  lsu_pkg::lsu_op_e  dpu_op_i;
  lsu_pkg::word_t    dpu_pc_i;
  lsu_pkg::reg_idx_t dpu_rd_i;
  lsu_pkg::imm_t     dpu_imm_i;
  lsu_pkg::word_t    dpu_rs1_data_i;
  lsu_pkg::word_t    dpu_rs2_data_i;
  logic              lsu_vld_o;
  logic              lsu_retired_o;
  logic              lsu_freeze_o;
  logic              lsu_trap_o;
  lsu_pkg::word_t    lsu_pc_o;
  lsu_pkg::word_t    lsu_pc_next_o;
  lsu_pkg::reg_idx_t lsu_rd_o;
  logic              lsu_rd_wr_o;
  lsu_pkg::word_t    lsu_rd_data_o;
  lsu_pkg::word_t    lsu_mem_rdata_o;
  logic              bus_cyc_o;
  logic              bus_stb_o;
  logic              bus_we_o;
  lsu_pkg::word_t    bus_adr_o;
  lsu_pkg::word_t    bus_dat_o;
  lsu_pkg::sel_t     bus_sel_o;
  logic              bus_ack_i;
  lsu_pkg::word_t    bus_dat_i;

  row_t              rows[$];
  lsu_pkg::word_t    mem [MEM_WORDS];
  lsu_pkg::word_t    ack_word;
  logic [15:0]       lfsr_state;
  logic [1:0]        ack_delay;
  logic [3:0]        mem_idx;
  int                cycle_count = 0;
  int                cycle_limit = 1000;
  int                wi;
  int                bi;

  lsu_top UUT (.*);

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic fail_and_stop(input string why);
    $display("%s", why);
    $display("tests failed");
    $fatal(1, "run stopped at time %0t", $time);
  endtask

  task automatic word_eq(input string name, input lsu_pkg::word_t exp, input lsu_pkg::word_t act);
    if (act !== exp)
      fail_and_stop($sformatf("Error at time %0t: %s expected %h got %h", $time, name, exp, act));
  endtask

  task automatic sel_eq(input string name, input lsu_pkg::sel_t exp, input lsu_pkg::sel_t act);
    if (act !== exp)
      fail_and_stop($sformatf("Error at time %0t: %s expected %h got %h", $time, name, exp, act));
  endtask

  task automatic reg_eq(input string name, input lsu_pkg::reg_idx_t exp,
                        input lsu_pkg::reg_idx_t act);
    if (act !== exp)
      fail_and_stop($sformatf("Error at time %0t: %s expected %h got %h", $time, name, exp, act));
  endtask

  task automatic bit_eq(input string name, input logic exp, input logic act);
    if (act !== exp)
      fail_and_stop($sformatf("Error at time %0t: %s expected %b got %b", $time, name, exp, act));
  endtask

  // 16-bit Fibonacci LFSR with taps 16, 14, 13 and 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // every byte of the preload depends on the word index
  function automatic lsu_pkg::word_t fill_word(input logic [3:0] idx);
    logic [7:0] i8;
    i8 = {4'h0, idx};
    return {i8 ^ 8'h81, i8 ^ 8'h7E, i8 ^ 8'hF2, i8 ^ 8'h13};
  endfunction

  task automatic add_row(input lsu_pkg::lsu_op_e op, input lsu_pkg::word_t pc,
                         input lsu_pkg::reg_idx_t rd, input lsu_pkg::word_t rs1,
                         input lsu_pkg::imm_t imm, input lsu_pkg::word_t rs2,
                         input lsu_pkg::word_t exp_data, input logic exp_trap,
                         input lsu_pkg::sel_t exp_sel);
    rows.push_back(row_t'{op, pc, rd, rs1, imm, rs2, exp_data, exp_trap, exp_sel});
  endtask

  // slave model with a random acknowledge delay of 1 to 4 cycles
  initial
  begin
    lfsr_state = 16'd24;
    for (wi = 0; wi < MEM_WORDS; wi++)
      mem[wi] = fill_word(4'(wi));
    ack_word  = '0;
    bus_ack_i = 1'b0;
    bus_dat_i = '0;
    forever
    begin
      @(posedge clk);
      #DRV_DELAY;
      bus_ack_i = 1'b0;
      if (!rst && bus_cyc_o && bus_stb_o)
      begin
        mem_idx = bus_adr_o[5:2];
        for (bi = 0; bi < 2; bi++)
        begin
          lfsr_state    = lfsr_step(lfsr_state);
          ack_delay[bi] = lfsr_state[0];
        end
        repeat (int'(ack_delay) + 1) @(posedge clk);
        #DRV_DELAY;
        ack_word  = mem[mem_idx];
        bus_dat_i = mem[mem_idx];
        bus_ack_i = 1'b1;
        if (bus_we_o)
          for (bi = 0; bi < 4; bi++)
            if (bus_sel_o[bi])
              mem[mem_idx][8*bi +: 8] = bus_dat_o[8*bi +: 8];
      end
    end
  end

  task automatic run_row(input row_t r);
    lsu_pkg::word_t imm_ext;
    lsu_pkg::word_t exp_adr;
    logic           is_store;
    logic           is_load;
    logic           done;
    int             stb_seen;
    int             wr_seen;
    imm_ext  = {{20{r.imm[11]}}, r.imm};
    exp_adr  = (r.rs1 + imm_ext) & 32'hFFFF_FFFC;
    is_store = (r.op == lsu_pkg::OP_SB) || (r.op == lsu_pkg::OP_SH) || (r.op == lsu_pkg::OP_SW);
    is_load  = (r.op == lsu_pkg::OP_LB) || (r.op == lsu_pkg::OP_LH) || (r.op == lsu_pkg::OP_LW)
            || (r.op == lsu_pkg::OP_LBU) || (r.op == lsu_pkg::OP_LHU);
    dpu_vld_i      = 1'b1;
    dpu_op_i       = r.op;
    dpu_pc_i       = r.pc;
    dpu_rd_i       = r.rd;
    dpu_rs1_data_i = r.rs1;
    dpu_imm_i      = r.imm;
    dpu_rs2_data_i = r.rs2;
    stb_seen = 0;
    wr_seen  = 0;
    done     = 1'b0;
    while (!done)
    begin
      @(posedge clk);
      #DRV_DELAY;
      bit_eq("lsu_vld_o", 1'b1, lsu_vld_o);
      if (bus_stb_o)
      begin
        stb_seen++;
        bit_eq("bus_cyc_o", 1'b1, bus_cyc_o);
        word_eq("bus_adr_o", exp_adr, bus_adr_o);
        sel_eq("bus_sel_o", r.exp_sel, bus_sel_o);
        bit_eq("bus_we_o", is_store, bus_we_o);
        if (is_store)
          word_eq("bus_dat_o", r.exp_data, bus_dat_o);
      end
      if (lsu_rd_wr_o)
        wr_seen++;
      done = lsu_retired_o;
      if (!done)
        bit_eq("lsu_freeze_o", 1'b1, lsu_freeze_o);
    end
    bit_eq("lsu_freeze_o", 1'b0, lsu_freeze_o);
    bit_eq("lsu_trap_o", r.exp_trap, lsu_trap_o);
    word_eq("lsu_pc_o", r.pc, lsu_pc_o);
    reg_eq("lsu_rd_o", r.rd, lsu_rd_o);
    if (is_store || is_load)
    begin
      if (stb_seen != 1)
        fail_and_stop($sformatf("access at pc %h raised %0d bus strobes", r.pc, stb_seen));
      word_eq("lsu_pc_next_o", r.pc + 32'd4, lsu_pc_next_o);
    end
    else if (stb_seen != 0)
      fail_and_stop($sformatf("invalid opcode at pc %h started a bus cycle", r.pc));
    // the write pulse of a load must be gone by the next instruction
    if (wr_seen != (is_load ? 1 : 0))
      fail_and_stop($sformatf("rd write pulse seen %0d times at pc %h", wr_seen, r.pc));
    if (is_load)
    begin
      word_eq("lsu_rd_data_o", r.exp_data, lsu_rd_data_o);
      word_eq("lsu_mem_rdata_o", ack_word, lsu_mem_rdata_o);
    end
  endtask

  always @(posedge clk)
  begin
    cycle_count = cycle_count + 1;
    if (cycle_count > cycle_limit)
      fail_and_stop($sformatf("timeout after %0d cycles without a retire", cycle_count));
  end

  initial
  begin
    rst            = 1'b1;
    dpu_vld_i      = 1'b0;
    dpu_op_i       = lsu_pkg::OP_NONE;
    dpu_pc_i       = '0;
    dpu_rd_i       = '0;
    dpu_imm_i      = '0;
    dpu_rs1_data_i = '0;
    dpu_rs2_data_i = '0;
    // each row holds op, pc, rd, rs1, imm, rs2, expected data, trap and lanes
    // expected data is the rd value for loads and the bus word for stores
    // word 2 preloads as 837cf011 and word 5 as 847bf716
    add_row(lsu_pkg::OP_LB, 32'h100, 5'd1, 32'h8, 12'h000, 32'h0, 32'h00000011, 1'b0, 4'h1);
    add_row(lsu_pkg::OP_LB, 32'h104, 5'd2, 32'h8, 12'h001, 32'h0, 32'hFFFFFFF0, 1'b0, 4'h2);
    add_row(lsu_pkg::OP_LB, 32'h108, 5'd3, 32'h30, 12'hFDA, 32'h0, 32'h0000007C, 1'b0, 4'h4);
    add_row(lsu_pkg::OP_LB, 32'h10C, 5'd4, 32'h8, 12'h003, 32'h0, 32'hFFFFFF83, 1'b0, 4'h8);
    add_row(lsu_pkg::OP_LBU, 32'h110, 5'd5, 32'h9, 12'h000, 32'h0, 32'h000000F0, 1'b0, 4'h2);
    add_row(lsu_pkg::OP_LBU, 32'h114, 5'd6, 32'hB, 12'h000, 32'h0, 32'h00000083, 1'b0, 4'h8);
    add_row(lsu_pkg::OP_LBU, 32'h118, 5'd7, 32'h8, 12'h000, 32'h0, 32'h00000011, 1'b0, 4'h1);
    add_row(lsu_pkg::OP_LBU, 32'h11C, 5'd8, 32'hA, 12'h000, 32'h0, 32'h0000007C, 1'b0, 4'h4);
    add_row(lsu_pkg::OP_LH, 32'h120, 5'd9, 32'h4, 12'h004, 32'h0, 32'hFFFFF011, 1'b0, 4'h3);
    add_row(lsu_pkg::OP_LH, 32'h124, 5'd10, 32'hA, 12'h000, 32'h0, 32'hFFFF837C, 1'b0, 4'hC);
    add_row(lsu_pkg::OP_LHU, 32'h128, 5'd11, 32'h10000008, 12'h000, 32'h0, 32'h0000F011, 1'b0,
            4'h3);
    add_row(lsu_pkg::OP_LHU, 32'h12C, 5'd12, 32'h10, 12'hFFA, 32'h0, 32'h0000837C, 1'b0, 4'hC);
    add_row(lsu_pkg::OP_LW, 32'h130, 5'd13, 32'h48, 12'hFC0, 32'h0, 32'h837CF011, 1'b0, 4'hF);
    add_row(lsu_pkg::OP_SB, 32'h134, 5'd0, 32'h14, 12'h001, 32'h123456AB, 32'h0000AB00, 1'b0,
            4'h2);
    add_row(lsu_pkg::OP_SH, 32'h138, 5'd0, 32'h10, 12'h006, 32'hCAFEBEEF, 32'hBEEF0000, 1'b0,
            4'hC);
    add_row(lsu_pkg::OP_LW, 32'h13C, 5'd14, 32'h14, 12'h000, 32'h0, 32'hBEEFAB16, 1'b0, 4'hF);
    add_row(lsu_pkg::OP_SB, 32'h140, 5'd0, 32'h17, 12'h000, 32'h5A, 32'h5A000000, 1'b0, 4'h8);
    add_row(lsu_pkg::OP_LBU, 32'h144, 5'd15, 32'h17, 12'h000, 32'h0, 32'h0000005A, 1'b0, 4'h8);
    add_row(lsu_pkg::OP_SW, 32'h148, 5'd0, 32'h20, 12'hFF8, 32'hDEADBEEF, 32'hDEADBEEF, 1'b0,
            4'hF);
    add_row(lsu_pkg::OP_SH, 32'h14C, 5'd0, 32'h18, 12'h000, 32'hFFFF1234, 32'h00001234, 1'b0,
            4'h3);
    add_row(lsu_pkg::OP_SB, 32'h150, 5'd0, 32'h18, 12'h002, 32'hABCDEF77, 32'h00770000, 1'b0,
            4'h4);
    add_row(lsu_pkg::OP_LW, 32'h154, 5'd16, 32'h18, 12'h000, 32'h0, 32'hDE771234, 1'b0, 4'hF);
    add_row(lsu_pkg::OP_NONE, 32'h15C, 5'd18, 32'h8, 12'h000, 32'h0, 32'h0, 1'b1, 4'h0);
    add_row(lsu_pkg::lsu_op_e'(4'd9), 32'h160, 5'd19, 32'h8, 12'h000, 32'h0, 32'h0, 1'b1, 4'h0);
    // misaligned PC traps but the access still runs
    add_row(lsu_pkg::OP_LW, 32'h166, 5'd20, 32'h8, 12'h000, 32'h0, 32'h837CF011, 1'b1, 4'hF);
    add_row(lsu_pkg::OP_SB, 32'h16B, 5'd0, 32'h24, 12'h001, 32'h99, 32'h00009900, 1'b1, 4'h2);
    add_row(lsu_pkg::OP_LW, 32'h170, 5'd0, 32'h8, 12'h000, 32'h0, 32'h0, 1'b0, 4'hF);
    cycle_limit = 10 * rows.size() + RST_CYCLES;
    repeat (RST_CYCLES) @(posedge clk);
    #DRV_DELAY;
    rst = 1'b0;
    bit_eq("lsu_vld_o", 1'b0, lsu_vld_o);
    bit_eq("bus_cyc_o", 1'b0, bus_cyc_o);
    bit_eq("bus_we_o", 1'b0, bus_we_o);
    word_eq("lsu_rd_data_o", 32'h0, lsu_rd_data_o);
    word_eq("bus_adr_o", 32'h0, bus_adr_o);
    foreach (rows[n])
      run_row(rows[n]);
    dpu_vld_i = 1'b0;
    @(posedge clk);
    #DRV_DELAY;
    bit_eq("lsu_vld_o", 1'b0, lsu_vld_o);
    bit_eq("lsu_rd_wr_o", 1'b0, lsu_rd_wr_o);
    $display("all tests passed");
    $finish;
  end

endmodule

// File: hdl/lsu_access_if.sv
`timescale 1ns/1ps

// carries the captured instruction out of the controller and the computed
// access back, everything here is combinational from controller registers
interface lsu_access_if;
  lsu_pkg::lsu_op_e   op;
  lsu_pkg::reg_idx_t  rd;
  lsu_pkg::word_t     rs1;
  lsu_pkg::word_t     rs2;
  lsu_pkg::imm_t      imm;
  lsu_pkg::word_t     addr;
  lsu_pkg::lane_off_t offset;
  lsu_pkg::sel_t      sel;
  lsu_pkg::word_t     wdata;
  logic               is_store;

  modport gen (input op, rs1, rs2, imm, output addr, offset, sel, wdata, is_store);

  modport ctrl (output op, rd, rs1, rs2, imm, input addr, offset, sel, wdata, is_store);

  modport align (input op, rd, offset);

endinterface

// File: hdl/lsu_addr_gen.sv
`timescale 1ns/1ps

module lsu_addr_gen (
  lsu_access_if.gen acc
);

  localparam int OFF_W = $bits(lsu_pkg::lane_off_t);
  localparam int EXT_W = lsu_pkg::XLEN - lsu_pkg::IMM_W;

  lsu_pkg::word_t imm_ext;
  lsu_pkg::word_t eff_addr;
  lsu_pkg::word_t byte_data;
  lsu_pkg::word_t half_data;

  assign imm_ext  = {{EXT_W{acc.imm[lsu_pkg::IMM_W-1]}}, acc.imm};
  assign eff_addr = acc.rs1 + imm_ext;

  // the bus only sees word addresses, the offset picks the lanes
  assign acc.addr   = {eff_addr[lsu_pkg::XLEN-1:OFF_W], {OFF_W{1'b0}}};
  assign acc.offset = eff_addr[OFF_W-1:0];

  assign byte_data = lsu_pkg::word_t'(acc.rs2[7:0]);
  assign half_data = lsu_pkg::word_t'(acc.rs2[15:0]);

  always_comb
  begin
    acc.sel      = '0;
    acc.wdata    = '0;
    acc.is_store = 1'b0;
    case (acc.op)
      lsu_pkg::OP_LB, lsu_pkg::OP_LBU:
        acc.sel = lsu_pkg::sel_t'(1) << acc.offset;
      lsu_pkg::OP_LH, lsu_pkg::OP_LHU:
        acc.sel = lsu_pkg::sel_t'(3) << {acc.offset[1], 1'b0};
      lsu_pkg::OP_LW:
        acc.sel = '1;
      lsu_pkg::OP_SB:
      begin
        acc.sel      = lsu_pkg::sel_t'(1) << acc.offset;
        acc.wdata    = byte_data << {acc.offset, 3'b000};
        acc.is_store = 1'b1;
      end
      lsu_pkg::OP_SH:
      begin
        // halves go to the lower or upper pair of lanes
        acc.sel      = lsu_pkg::sel_t'(3) << {acc.offset[1], 1'b0};
        acc.wdata    = half_data << {acc.offset[1], 4'b0000};
        acc.is_store = 1'b1;
      end
      lsu_pkg::OP_SW:
      begin
        acc.sel      = '1;
        acc.wdata    = acc.rs2;
        acc.is_store = 1'b1;
      end
      default: acc.sel = '0;
    endcase
  end

endmodule

// File: hdl/lsu_ctrl_fsm.sv
`timescale 1ns/1ps

module lsu_ctrl_fsm (
  input  logic                clk,
  input  logic                rst,
  input  logic                dpu_vld_i,
  input  lsu_pkg::lsu_op_e    dpu_op_i,
  input  lsu_pkg::word_t      dpu_pc_i,
  input  lsu_pkg::reg_idx_t   dpu_rd_i,
  input  lsu_pkg::imm_t       dpu_imm_i,
  input  lsu_pkg::word_t      dpu_rs1_data_i,
  input  lsu_pkg::word_t      dpu_rs2_data_i,
  input  logic                bus_ack_i,
  output logic                lsu_vld_o,
  output logic                lsu_retired_o,
  output logic                lsu_freeze_o,
  output logic                lsu_trap_o,
  output lsu_pkg::word_t      lsu_pc_o,
  output lsu_pkg::word_t      lsu_pc_next_o,
  output lsu_pkg::reg_idx_t   lsu_rd_o,
  output logic                bus_cyc_o,
  output logic                bus_stb_o,
  output logic                bus_we_o,
  output lsu_pkg::word_t      bus_adr_o,
  output lsu_pkg::word_t      bus_dat_o,
  output lsu_pkg::sel_t       bus_sel_o,
  lsu_access_if.ctrl          acc
);

  lsu_pkg::lsu_state_e state;
  lsu_pkg::lsu_op_e    op_q;
  lsu_pkg::word_t      rs1_q;
  lsu_pkg::word_t      rs2_q;
  lsu_pkg::imm_t       imm_q;
  logic                accept;
  logic                op_valid;
  logic                pc_misaligned;

  assign acc.op  = op_q;
  assign acc.rd  = lsu_rd_o;
  assign acc.rs1 = rs1_q;
  assign acc.rs2 = rs2_q;
  assign acc.imm = imm_q;

  // take a new instruction when empty or in the retire cycle
  assign accept        = dpu_vld_i & (~lsu_vld_o | lsu_retired_o);
  assign pc_misaligned = |lsu_pc_o[1:0];

  always_comb
  begin
    case (op_q)
      lsu_pkg::OP_LB, lsu_pkg::OP_LH, lsu_pkg::OP_LW, lsu_pkg::OP_LBU,
      lsu_pkg::OP_LHU, lsu_pkg::OP_SB, lsu_pkg::OP_SH, lsu_pkg::OP_SW: op_valid = 1'b1;
      default: op_valid = 1'b0;
    endcase
  end

  // operands only matter while an instruction is held
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      rs1_q <= dpu_rs1_data_i;
      rs2_q <= dpu_rs2_data_i;
      imm_q <= dpu_imm_i;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state         <= lsu_pkg::ST_IDLE;
      op_q          <= lsu_pkg::OP_NONE;
      lsu_vld_o     <= 1'b0;
      lsu_retired_o <= 1'b0;
      lsu_freeze_o  <= 1'b0;
      lsu_trap_o    <= 1'b0;
      lsu_pc_o      <= '0;
      lsu_pc_next_o <= '0;
      lsu_rd_o      <= '0;
      bus_cyc_o     <= 1'b0;
      bus_stb_o     <= 1'b0;
      bus_we_o      <= 1'b0;
      bus_adr_o     <= '0;
      bus_dat_o     <= '0;
      bus_sel_o     <= '0;
    end
    else
    begin
      // strobe, retire and trap are single-cycle pulses
      lsu_retired_o <= 1'b0;
      lsu_trap_o    <= 1'b0;
      bus_cyc_o     <= 1'b0;
      bus_stb_o     <= 1'b0;

      if (accept)
      begin
        lsu_vld_o    <= 1'b1;
        lsu_freeze_o <= 1'b1;
        op_q         <= dpu_op_i;
        lsu_pc_o     <= dpu_pc_i;
        lsu_rd_o     <= dpu_rd_i;
      end
      else if (lsu_retired_o)
        lsu_vld_o <= 1'b0;

      case (state)
        lsu_pkg::ST_IDLE:
        begin
          if (lsu_vld_o && op_valid)
          begin
            state     <= lsu_pkg::ST_ISSUE;
            bus_cyc_o <= 1'b1;
            bus_stb_o <= 1'b1;
            bus_adr_o <= acc.addr;
            bus_we_o  <= acc.is_store;
            bus_sel_o <= acc.sel;
            if (acc.is_store)
              bus_dat_o <= acc.wdata;
          end
          else if (lsu_vld_o)
          begin
            // not a memory access, retire at once with a trap
            state         <= lsu_pkg::ST_RETIRE;
            lsu_retired_o <= 1'b1;
            lsu_trap_o    <= 1'b1;
            lsu_freeze_o  <= 1'b0;
          end
        end
        lsu_pkg::ST_ISSUE: state <= lsu_pkg::ST_WAIT;
        lsu_pkg::ST_WAIT:
        begin
          // no bound on the wait, the slave must answer eventually
          if (bus_ack_i)
          begin
            state         <= lsu_pkg::ST_RETIRE;
            lsu_retired_o <= 1'b1;
            lsu_freeze_o  <= 1'b0;
            lsu_trap_o    <= pc_misaligned;
            lsu_pc_next_o <= lsu_pc_o + lsu_pkg::PC_STEP;
          end
        end
        default: state <= lsu_pkg::ST_IDLE;
      endcase
    end
  end

endmodule

// File: hdl/lsu_load_align.sv
`timescale 1ns/1ps

module lsu_load_align (
  input  logic           clk,
  input  logic           rst,
  input  logic           bus_ack_i,
  input  lsu_pkg::word_t bus_dat_i,
  output logic           lsu_rd_wr_o,
  output lsu_pkg::word_t lsu_rd_data_o,
  output lsu_pkg::word_t lsu_mem_rdata_o,
  lsu_access_if.align    acc
);

  localparam int B_EXT = lsu_pkg::XLEN - 8;
  localparam int H_EXT = lsu_pkg::XLEN - 16;

  lsu_pkg::word_t byte_lane;
  lsu_pkg::word_t half_lane;
  lsu_pkg::word_t load_val;
  logic           is_load;

  // move the addressed lane down to bit 0
  assign byte_lane = bus_dat_i >> {acc.offset, 3'b000};
  assign half_lane = bus_dat_i >> {acc.offset[1], 4'b0000};

  always_comb
  begin
    is_load  = 1'b1;
    load_val = '0;
    case (acc.op)
      lsu_pkg::OP_LB:  load_val = {{B_EXT{byte_lane[7]}}, byte_lane[7:0]};
      lsu_pkg::OP_LBU: load_val = {{B_EXT{1'b0}}, byte_lane[7:0]};
      lsu_pkg::OP_LH:  load_val = {{H_EXT{half_lane[15]}}, half_lane[15:0]};
      lsu_pkg::OP_LHU: load_val = {{H_EXT{1'b0}}, half_lane[15:0]};
      lsu_pkg::OP_LW:  load_val = bus_dat_i;
      default:         is_load  = 1'b0;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      lsu_rd_wr_o     <= 1'b0;
      lsu_rd_data_o   <= '0;
      lsu_mem_rdata_o <= '0;
    end
    else
    begin
      lsu_rd_wr_o <= 1'b0;
      if (bus_ack_i)
        lsu_mem_rdata_o <= bus_dat_i;
      if (bus_ack_i && is_load)
      begin
        lsu_rd_wr_o <= 1'b1;
        // x0 is hardwired to zero
        lsu_rd_data_o <= (acc.rd == '0) ? '0 : load_val;
      end
    end
  end

endmodule

// File: hdl/lsu_pkg.sv
package lsu_pkg;

  // datapath widths, the byte-lane logic assumes a 32-bit word
  localparam int XLEN  = 32;
  localparam int IMM_W = 12;
  localparam int LANES = 4;
  localparam int REG_W = 5;

  typedef logic [XLEN-1:0]          word_t;
  typedef logic [LANES-1:0]         sel_t;
  typedef logic [IMM_W-1:0]         imm_t;
  typedef logic [REG_W-1:0]         reg_idx_t;
  typedef logic [$clog2(LANES)-1:0] lane_off_t;

  // next PC after a completed access
  localparam word_t PC_STEP = word_t'(4);

  // memory opcodes from decode, anything outside the list traps
  typedef enum logic [3:0] {
    OP_NONE = 4'd0,
    OP_LB   = 4'd1,
    OP_LH   = 4'd2,
    OP_LW   = 4'd3,
    OP_LBU  = 4'd4,
    OP_LHU  = 4'd5,
    OP_SB   = 4'd6,
    OP_SH   = 4'd7,
    OP_SW   = 4'd8
  } lsu_op_e;

  // ST_IDLE also covers a captured instruction that has not issued yet
  typedef enum logic [1:0] {
    ST_IDLE   = 2'd0,
    ST_ISSUE  = 2'd1,
    ST_WAIT   = 2'd2,
    ST_RETIRE = 2'd3
  } lsu_state_e;

endpackage

// File: hdl/lsu_top.sv
`timescale 1ns/1ps

module lsu_top (
  input  logic                clk,
  input  logic                rst,
  input  logic                dpu_vld_i,
  input  lsu_pkg::lsu_op_e    dpu_op_i,
  input  lsu_pkg::word_t      dpu_pc_i,
  input  lsu_pkg::reg_idx_t   dpu_rd_i,
  input  lsu_pkg::imm_t       dpu_imm_i,
  input  lsu_pkg::word_t      dpu_rs1_data_i,
  input  lsu_pkg::word_t      dpu_rs2_data_i,
  output logic                lsu_vld_o,
  output logic                lsu_retired_o,
  output logic                lsu_freeze_o,
  output logic                lsu_trap_o,
  output lsu_pkg::word_t      lsu_pc_o,
  output lsu_pkg::word_t      lsu_pc_next_o,
  output lsu_pkg::reg_idx_t   lsu_rd_o,
  output logic                lsu_rd_wr_o,
  output lsu_pkg::word_t      lsu_rd_data_o,
  output lsu_pkg::word_t      lsu_mem_rdata_o,
  output logic                bus_cyc_o,
  output logic                bus_stb_o,
  output logic                bus_we_o,
  output lsu_pkg::word_t      bus_adr_o,
  output lsu_pkg::word_t      bus_dat_o,
  output lsu_pkg::sel_t       bus_sel_o,
  input  logic                bus_ack_i,
  input  lsu_pkg::word_t      bus_dat_i
);

  lsu_access_if acc ();

  // owns the instruction registers and the bus cycle
  lsu_ctrl_fsm u_ctrl (
    .clk            (clk),
    .rst            (rst),
    .dpu_vld_i      (dpu_vld_i),
    .dpu_op_i       (dpu_op_i),
    .dpu_pc_i       (dpu_pc_i),
    .dpu_rd_i       (dpu_rd_i),
    .dpu_imm_i      (dpu_imm_i),
    .dpu_rs1_data_i (dpu_rs1_data_i),
    .dpu_rs2_data_i (dpu_rs2_data_i),
    .bus_ack_i      (bus_ack_i),
    .lsu_vld_o      (lsu_vld_o),
    .lsu_retired_o  (lsu_retired_o),
    .lsu_freeze_o   (lsu_freeze_o),
    .lsu_trap_o     (lsu_trap_o),
    .lsu_pc_o       (lsu_pc_o),
    .lsu_pc_next_o  (lsu_pc_next_o),
    .lsu_rd_o       (lsu_rd_o),
    .bus_cyc_o      (bus_cyc_o),
    .bus_stb_o      (bus_stb_o),
    .bus_we_o       (bus_we_o),
    .bus_adr_o      (bus_adr_o),
    .bus_dat_o      (bus_dat_o),
    .bus_sel_o      (bus_sel_o),
    .acc            (acc)
  );

  lsu_addr_gen u_addr_gen (
    .acc (acc)
  );

  lsu_load_align u_load_align (
    .clk             (clk),
    .rst             (rst),
    .bus_ack_i       (bus_ack_i),
    .bus_dat_i       (bus_dat_i),
    .lsu_rd_wr_o     (lsu_rd_wr_o),
    .lsu_rd_data_o   (lsu_rd_data_o),
    .lsu_mem_rdata_o (lsu_mem_rdata_o),
    .acc             (acc)
  );

endmodule

// File: lsu.f
hdl/lsu_pkg.sv
hdl/lsu_access_if.sv
hdl/lsu_ctrl_fsm.sv
hdl/lsu_addr_gen.sv
hdl/lsu_load_align.sv
hdl/lsu_top.sv
dv/lsu_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the LSU testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module lsu_tb -f lsu.f -o lsu_sim > build.log 2>&1 \
  || { cat build.log; echo "verilator build failed"; exit 1; }
./obj_dir/lsu_sim > sim.log 2>&1 || true
cat sim.log
grep -q "tests failed" sim.log && { echo "simulation FAILED"; exit 1; }
grep -q "all tests passed" sim.log || { echo "simulation did not complete"; exit 1; }
echo "simulation PASSED"
